/* source/frontend_pkg.sv */
/*
  Shared widths, types and encodings of the fetch front end.
  The PC is word granular, so byte addresses are the PC followed by p_insn_len zeros.
  Fetch and issue width are fixed at one instruction.
*/
package frontend_pkg;

   // Address and instruction widths
   localparam int addr_w     = 32;
   localparam int insn_w     = 32;
   localparam int p_insn_len = 2;
   localparam int pc_w       = addr_w - p_insn_len;

   // Fetch queue geometry
   localparam int iq_depth   = 4;
   localparam int p_iq_depth = 2;

   typedef logic [pc_w-1:0]   pc_t;
   typedef logic [insn_w-1:0] insn_t;

   // Word PC loaded at reset
   localparam pc_t reset_vector = '0;

   // Memory request machine
   typedef enum logic [1:0] {
      fetch_idle         = 2'd0,
      fetch_wait_ack     = 2'd1,
      fetch_wait_release = 2'd2
   } fetch_state_e;

   // Per-entry fetch exception
   typedef enum logic [0:0] {
      exc_none    = 1'b0,
      exc_bus_err = 1'b1
   } fetch_exc_e;

endpackage

/* source/fetch_ctrl.sv */
/*
  PC register and four-phase request machine towards instruction memory.
  Only one fetch is in flight; a flush during it marks the response stale.
  The address is held from the request edge until ack is seen high.
*/
`timescale 1ns/100ps

module fetch_ctrl (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            flush,
   input  frontend_pkg::pc_t               flush_tgt,
   input  logic                            imem_ack,
   input  frontend_pkg::insn_t             imem_rdata,
   input  logic                            imem_err,
   input  logic                            full,
   output logic                            imem_req,
   output logic [frontend_pkg::addr_w-1:0] imem_addr,
   output logic                            push,
   output frontend_pkg::insn_t             push_ins,
   output frontend_pkg::pc_t               push_pc,
   output frontend_pkg::fetch_exc_e        push_exc
);

   frontend_pkg::fetch_state_e state;
   frontend_pkg::pc_t          pc;
   frontend_pkg::pc_t          req_pc;
   logic                       stale;
   logic                       start_req;
   logic                       ack_taken;

   // New request only from idle, with room in the queue
   assign start_req = (state == frontend_pkg::fetch_idle) && !flush && !full;

   assign ack_taken = (state == frontend_pkg::fetch_wait_ack) && imem_ack;

   // A stale response or one meeting a flush is dropped
   assign push = ack_taken && !stale && !flush;

   assign push_ins = imem_rdata;
   assign push_pc  = req_pc;
   assign push_exc = imem_err ? frontend_pkg::exc_bus_err : frontend_pkg::exc_none;

   assign imem_addr = {req_pc, {frontend_pkg::p_insn_len{1'b0}}};

   // Program counter
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= frontend_pkg::reset_vector;
      else if (flush)
         pc <= flush_tgt;
      else if (push)
         pc <= pc + 1'b1;
   end

   // PC of the fetch in flight
   always_ff @(posedge clk)
   begin
      if (start_req)
         req_pc <= pc;
   end

   // Four-phase handshake
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= frontend_pkg::fetch_idle;
         imem_req <= 1'b0;
         stale    <= 1'b0;
      end
      else
      begin
         case (state)
            frontend_pkg::fetch_idle:
            begin
               if (start_req)
               begin
                  imem_req <= 1'b1;
                  state    <= frontend_pkg::fetch_wait_ack;
               end
            end
            frontend_pkg::fetch_wait_ack:
            begin
               // Handshake still completes after a flush
               if (flush)
                  stale <= 1'b1;
               if (imem_ack)
               begin
                  imem_req <= 1'b0;
                  state    <= frontend_pkg::fetch_wait_release;
               end
            end
            frontend_pkg::fetch_wait_release:
            begin
               // Memory has dropped ack, req may rise again
               if (!imem_ack)
               begin
                  stale <= 1'b0;
                  state <= frontend_pkg::fetch_idle;
               end
            end
            default:
            begin
               imem_req <= 1'b0;
               stale    <= 1'b0;
               state    <= frontend_pkg::fetch_idle;
            end
         endcase
      end
   end

endmodule

/* source/fetch_queue.sv */
/*
  Circular fetch queue between fetch control and the decoder.
  Push and pop may share an edge; flush empties it and wins over both.
  Pushing into a full queue is not guarded, fetch control holds off instead.
*/
`timescale 1ns/100ps

module fetch_queue (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     flush,
   input  logic                     push,
   input  frontend_pkg::insn_t      push_ins,
   input  frontend_pkg::pc_t        push_pc,
   input  frontend_pkg::fetch_exc_e push_exc,
   input  logic                     id_pop,
   output logic                     full,
   output logic                     id_valid,
   output frontend_pkg::insn_t      id_ins,
   output frontend_pkg::pc_t        id_pc,
   output frontend_pkg::fetch_exc_e id_exc
);

   frontend_pkg::insn_t      ins_mem [frontend_pkg::iq_depth];
   frontend_pkg::pc_t        pc_mem  [frontend_pkg::iq_depth];
   frontend_pkg::fetch_exc_e exc_mem [frontend_pkg::iq_depth];

   logic [frontend_pkg::p_iq_depth-1:0] rptr;
   logic [frontend_pkg::p_iq_depth-1:0] wptr;
   logic [frontend_pkg::p_iq_depth:0]   count;
   logic                                pop;

   assign id_valid = (count != '0);
   assign full     = (count == (frontend_pkg::p_iq_depth + 1)'(frontend_pkg::iq_depth));

   // Pop without a valid entry is ignored
   assign pop = id_pop && id_valid;

   // Oldest entry towards the decoder
   assign id_ins = ins_mem[rptr];
   assign id_pc  = pc_mem[rptr];
   assign id_exc = exc_mem[rptr];

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         ins_mem[wptr] <= push_ins;
         pc_mem[wptr]  <= push_pc;
         exc_mem[wptr] <= push_exc;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wptr <= wptr + 1'b1;
         if (pop)
            rptr <= rptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* source/frontend.sv */
/*
  Fetch front end top level.
  Memory port uses a four-phase req/ack handshake with variable latency.
  Decoder pops one entry per edge with id_valid and id_pop both high.
*/
`timescale 1ns/100ps

module frontend (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            flush,
   input  frontend_pkg::pc_t               flush_tgt,
   // Decoder side
   input  logic                            id_pop,
   output logic                            id_valid,
   output frontend_pkg::insn_t             id_ins,
   output frontend_pkg::pc_t               id_pc,
   output frontend_pkg::fetch_exc_e        id_exc,
   // Instruction memory
   input  logic                            imem_ack,
   input  frontend_pkg::insn_t             imem_rdata,
   input  logic                            imem_err,
   output logic                            imem_req,
   output logic [frontend_pkg::addr_w-1:0] imem_addr
);

   logic                     push;
   frontend_pkg::insn_t      push_ins;
   frontend_pkg::pc_t        push_pc;
   frontend_pkg::fetch_exc_e push_exc;
   logic                     full;

   fetch_ctrl fetch_ctrl_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .imem_ack   (imem_ack),
      .imem_rdata (imem_rdata),
      .imem_err   (imem_err),
      .full       (full),
      .imem_req   (imem_req),
      .imem_addr  (imem_addr),
      .push       (push),
      .push_ins   (push_ins),
      .push_pc    (push_pc),
      .push_exc   (push_exc)
   );

   fetch_queue fetch_queue_i (
      .clk      (clk),
      .reset    (reset),
      .flush    (flush),
      .push     (push),
      .push_ins (push_ins),
      .push_pc  (push_pc),
      .push_exc (push_exc),
      .id_pop   (id_pop),
      .full     (full),
      .id_valid (id_valid),
      .id_ins   (id_ins),
      .id_pc    (id_pc),
      .id_exc   (id_exc)
   );

endmodule

/* sim/frontend_properties.sv */
/*
  Handshake and reset checks for the fetch front end, bound into frontend.
  Checks are sampled on the rising clock edge and idle while reset is high,
  except the reset rule itself.
*/
`timescale 1ns/100ps

module frontend_properties (
   input logic                            clk,
   input logic                            reset,
   input logic                            imem_req,
   input logic                            imem_ack,
   input logic [frontend_pkg::addr_w-1:0] imem_addr,
   input logic                            id_valid,
   input logic                            full
);

   // Req and address held until ack
   req_held: assert property (@(posedge clk) disable iff (reset)
      imem_req && !imem_ack |=> imem_req)
      else $error("imem_req dropped before imem_ack was seen");

   addr_stable: assert property (@(posedge clk) disable iff (reset)
      imem_req && !imem_ack |=> $stable(imem_addr))
      else $error("imem_addr changed while waiting for imem_ack");

   // Req drops once ack is seen
   req_released: assert property (@(posedge clk) disable iff (reset)
      imem_req && imem_ack |=> !imem_req)
      else $error("imem_req still high after imem_ack");

   // No new request until ack is low
   no_req_during_ack: assert property (@(posedge clk) disable iff (reset)
      !imem_req && imem_ack |=> !imem_req)
      else $error("imem_req rose while imem_ack was still high");

   // Full queue holds off the next request
   no_req_when_full: assert property (@(posedge clk) disable iff (reset)
      full && !imem_req |=> !imem_req)
      else $error("imem_req rose while the fetch queue was full");

   reset_quiet: assert property (@(posedge clk)
      reset |=> !imem_req && !id_valid)
      else $error("imem_req or id_valid high during or right after reset");

endmodule

/* sim/frontend_tb.sv */
/*
  Testbench for the fetch front end with a four-phase instruction memory model.
  Memory answers after 0 to 5 cycles with data = byte address ^ 32'h5a5a_0000,
  holds ack 0 to 2 cycles after req drops,
  and reports a bus error for word PCs 40 to 43 hex.
  Inputs change on the falling edge, outputs are sampled there as well.
*/
`timescale 1ns/100ps

module frontend_tb;

   localparam int unsigned clk_period     = 40;
   localparam int unsigned mem_delay_max  = 5;
   localparam int unsigned release_max    = 2;
   localparam int unsigned gap_max        = 12;
   localparam int unsigned flush_wait_max = 10;
   localparam int unsigned n_rows         = 6;

   localparam frontend_pkg::pc_t fault_lo = 30'h40;
   localparam frontend_pkg::pc_t fault_hi = 30'h43;

   typedef struct packed {
      logic              do_flush;
      frontend_pkg::pc_t tgt;
      int unsigned       pops;
      int unsigned       max_gap;
   } row_t;

   // Flush, target, entries to pop, max pop gap
   row_t rows [n_rows] = '{
      '{1'b0, 30'h0,   8,  0},
      '{1'b0, 30'h0,   10, 12},
      '{1'b1, 30'h3e,  8,  2},
      '{1'b1, 30'h100, 5,  0},
      '{1'b0, 30'h0,   6,  10},
      '{1'b1, 30'h2a5, 4,  3}
   };

   integer seed = 32'hfa8d_684a;

   logic                            clk;
   logic                            reset;
   logic                            flush;
   frontend_pkg::pc_t               flush_tgt;
   logic                            id_pop;
   logic                            id_valid;
   frontend_pkg::insn_t             id_ins;
   frontend_pkg::pc_t               id_pc;
   frontend_pkg::fetch_exc_e        id_exc;
   logic                            imem_ack;
   frontend_pkg::insn_t             imem_rdata;
   logic                            imem_err;
   logic                            imem_req;
   logic [frontend_pkg::addr_w-1:0] imem_addr;

   frontend frontend_i (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .id_pop     (id_pop),
      .id_valid   (id_valid),
      .id_ins     (id_ins),
      .id_pc      (id_pc),
      .id_exc     (id_exc),
      .imem_ack   (imem_ack),
      .imem_rdata (imem_rdata),
      .imem_err   (imem_err),
      .imem_req   (imem_req),
      .imem_addr  (imem_addr)
   );

   bind frontend frontend_properties frontend_properties_i (
      .clk       (clk),
      .reset     (reset),
      .imem_req  (imem_req),
      .imem_ack  (imem_ack),
      .imem_addr (imem_addr),
      .id_valid  (id_valid),
      .full      (full)
   );

   // Memory content for a word PC
   function automatic frontend_pkg::insn_t mem_word(input frontend_pkg::pc_t pc);
      return {pc, {frontend_pkg::p_insn_len{1'b0}}} ^ 32'h5a5a_0000;
   endfunction

   function automatic frontend_pkg::fetch_exc_e fault_of(input frontend_pkg::pc_t pc);
      if (pc >= fault_lo && pc <= fault_hi)
         return frontend_pkg::exc_bus_err;
      return frontend_pkg::exc_none;
   endfunction

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_pc(input string name, input frontend_pkg::pc_t actual,
                           input frontend_pkg::pc_t expected);
      if (actual !== expected)
      begin
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_ins(input string name, input frontend_pkg::insn_t actual,
                            input frontend_pkg::insn_t expected);
      if (actual !== expected)
      begin
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_exc(input string name, input frontend_pkg::fetch_exc_e actual,
                            input frontend_pkg::fetch_exc_e expected);
      if (actual !== expected)
      begin
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
         abort_run();
      end
   endtask

   // Idle for a while, then take and check one entry
   task automatic pop_and_check(input frontend_pkg::pc_t exp_pc, input int unsigned max_gap);
      int unsigned gap;
      // Upper half of the range, so long gaps really fill the queue
      gap = max_gap / 2 + $unsigned($random(seed)) % (max_gap / 2 + 1);
      repeat (gap) @(negedge clk);
      while (!id_valid)
         @(negedge clk);
      check_pc("id_pc", id_pc, exp_pc);
      check_ins("id_ins", id_ins, mem_word(exp_pc));
      check_exc("id_exc", id_exc, fault_of(exp_pc));
      id_pop = 1'b1;
      @(negedge clk);
      id_pop = 1'b0;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Instruction memory, four-phase slave
   initial
   begin
      int unsigned       delay;
      logic              counting;
      frontend_pkg::pc_t word;
      imem_ack   = 1'b0;
      imem_rdata = '0;
      imem_err   = 1'b0;
      delay      = 0;
      counting   = 1'b0;
      forever
      begin
         @(negedge clk);
         word = imem_addr[frontend_pkg::addr_w-1:frontend_pkg::p_insn_len];
         if (reset)
         begin
            imem_ack = 1'b0;
            counting = 1'b0;
         end
         else if (imem_ack)
         begin
            // Ack lingers a few cycles after req drops
            if (!imem_req)
            begin
               if (!counting)
               begin
                  delay    = $unsigned($random(seed)) % (release_max + 1);
                  counting = 1'b1;
               end
               if (delay == 0)
               begin
                  imem_ack = 1'b0;
                  counting = 1'b0;
               end
               else
                  delay = delay - 1;
            end
         end
         else if (imem_req)
         begin
            if (!counting)
            begin
               delay    = $unsigned($random(seed)) % (mem_delay_max + 1);
               counting = 1'b1;
            end
            if (delay == 0)
            begin
               imem_ack   = 1'b1;
               imem_rdata = imem_addr ^ 32'h5a5a_0000;
               imem_err   = (fault_of(word) == frontend_pkg::exc_bus_err);
               counting   = 1'b0;
            end
            else
               delay = delay - 1;
         end
      end
   end

   // Stimulus table
   initial
   begin
      frontend_pkg::pc_t expected_pc;
      int unsigned       waited;
      reset       = 1'b1;
      flush       = 1'b0;
      flush_tgt   = '0;
      id_pop      = 1'b0;
      expected_pc = frontend_pkg::reset_vector;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      for (int unsigned r = 0; r < n_rows; r++)
      begin
         if (rows[r].do_flush)
         begin
            // Aim the flush at a fetch in flight
            waited = 0;
            while (!imem_req && waited < flush_wait_max)
            begin
               @(negedge clk);
               waited++;
            end
            flush     = 1'b1;
            flush_tgt = rows[r].tgt;
            @(negedge clk);
            flush       = 1'b0;
            expected_pc = rows[r].tgt;
         end
         for (int unsigned n = 0; n < rows[r].pops; n++)
         begin
            pop_and_check(expected_pc, rows[r].max_gap);
            expected_pc = expected_pc + frontend_pkg::pc_t'(1);
         end
      end
      $display(">>> PASS");
      $finish;
   end

   // Watchdog sized from the table
   initial
   begin
      int unsigned total;
      int unsigned limit_cycles;
      total = 0;
      for (int unsigned i = 0; i < n_rows; i++)
         total += rows[i].pops;
      limit_cycles = total * (mem_delay_max + release_max + gap_max + 4)
                     + n_rows * flush_wait_max + 200;
      #(limit_cycles * clk_period);
      $display("Timeout: the testbench did not finish within %0d cycles", limit_cycles);
      abort_run();
   end

endmodule

/* compile.f */
source/frontend_pkg.sv
source/fetch_ctrl.sv
source/fetch_queue.sv
source/frontend.sv
sim/frontend_properties.sv
sim/frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the fetch front end testbench with Verilator.
# The exit status is zero only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module frontend_tb \
   -Mdir "$build_dir" \
   -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"./$build_dir/Vfrontend_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q -x -F '>>> PASS' "$log_file"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1
